// ==== ddr3_phy_vectors.txt ====
# record: cfg <word> <exp sel> <exp lat> | cmd <addr> <bank> <ctl> | wr <mask> <en> <n> | rd <en> <n> 0
# all hex; ctl bits 6..0 = cas_n cke cs_n odt ras_n reset_n we_n; en bits apply LSB first, one per cycle
cmd 0000 0 00
cmd 0000 0 02
cmd 1a2b 5 4c
cmd 3fff 7 7f
cmd 2aaa 2 55
cmd 1555 5 2a
cmd 0400 3 26
wr  f 0000000b 4
wr  5 0000001f 6
wr  a 00000005 5
rd  00000009 6 0
cfg 5a5a0301 1 3
rd  0000000f 6 0
cfg a5a5f20e e 2
rd  0000002d 7 0
cfg 12345409 9 4
rd  0000003f 8 0
cfg 00000706 6 7
rd  000000b5 9 0
cfg fffff80b b 0
rd  0000ffff 10 0
cfg 00000504 4 5
rd  00000077 8 0

// ==== project.f ====
ddr3_phy_pkg.sv
ddr3_phy_cfg.sv
ddr3_phy_cmd.sv
ddr3_phy_wr.sv
ddr3_phy_rd.sv
ddr3_dfi_phy_core.sv
ddr3_phy_checker.sv
tb_ddr3_phy.sv

// ==== Makefile ====
SRCS := $(shell grep -v '^+' project.f)

.PHONY: run clean

obj_dir/Vtb_ddr3_phy: project.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/10ps \
	  --top-module tb_ddr3_phy -f project.f -o Vtb_ddr3_phy

run: obj_dir/Vtb_ddr3_phy
	./obj_dir/Vtb_ddr3_phy > sim.log 2>&1; cat sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb_ddr3_phy.sv ====
`timescale 1ns/10ps

module tb_ddr3_phy;

  logic                                               clk_i;
  logic                                               rst_i;
  logic                                               cfg_req_i;
  logic [ddr3_phy_pkg::CFG_W-1:0]                     cfg_data_i;
  logic                                               cfg_ack_o;
  logic [ddr3_phy_pkg::ADDR_W-1:0]                    dfi_address_i;
  logic [ddr3_phy_pkg::BANK_W-1:0]                    dfi_bank_i;
  logic                                               dfi_cas_n_i;
  logic                                               dfi_cke_i;
  logic                                               dfi_cs_n_i;
  logic                                               dfi_odt_i;
  logic                                               dfi_ras_n_i;
  logic                                               dfi_reset_n_i;
  logic                                               dfi_we_n_i;
  logic [ddr3_phy_pkg::DFI_DATA_W-1:0]                dfi_wrdata_i;
  logic [ddr3_phy_pkg::DFI_MASK_W-1:0]                dfi_wrdata_mask_i;
  logic                                               dfi_wrdata_en_i;
  logic [ddr3_phy_pkg::BEATS*ddr3_phy_pkg::DQ_W-1:0]  rd_beats_i;
  logic                                               dfi_rddata_en_i;
  logic [ddr3_phy_pkg::DFI_DATA_W-1:0]                dfi_rddata_o;
  logic                                               dfi_rddata_valid_o;
  logic [ddr3_phy_pkg::ADDR_W-1:0]                    ddr3_addr_o;
  logic [ddr3_phy_pkg::BANK_W-1:0]                    ddr3_ba_o;
  logic                                               ddr3_cas_n_o;
  logic                                               ddr3_cke_o;
  logic                                               ddr3_cs_n_o;
  logic                                               ddr3_odt_o;
  logic                                               ddr3_ras_n_o;
  logic                                               ddr3_reset_n_o;
  logic                                               ddr3_we_n_o;
  logic [ddr3_phy_pkg::DFI_DATA_W-1:0]                ddr3_wrdata_o;
  logic [ddr3_phy_pkg::DFI_MASK_W-1:0]                ddr3_wrmask_o;
  logic                                               dq_oe_o;

  int              seed;
  int              err_cnt;
  int              tmo_cnt;
  int              fd;
  int              code;
  logic [63:0]     tok;
  logic [1023:0]   line;
  logic [31:0]     f1;
  logic [31:0]     f2;
  logic [31:0]     f3;
  // Model of the configured fields, reset values 15 and 4
  logic [3:0]      cur_sel;
  logic [2:0]      cur_lat;
  // Last values driven into the registered paths
  logic [23:0]     last_cmd;
  logic [31:0]     last_data;
  logic [3:0]      last_mask;
  logic [63:0]     last_beats;

  ddr3_dfi_phy_core dut_i (.*);

  always #2 clk_i = ~clk_i;

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  // Inputs change on the falling edge, outputs are read there too
  task automatic tick();
    @(posedge clk_i);
    @(negedge clk_i);
  endtask

  task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string what);
    assert (got === exp)
    else
    begin
      $display("[FAIL] %0t: %s is %0h, expected %0h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  function automatic logic [23:0] cmd_pins();
    return {ddr3_addr_o, ddr3_ba_o, ddr3_cas_n_o, ddr3_cke_o, ddr3_cs_n_o,
            ddr3_odt_o, ddr3_ras_n_o, ddr3_reset_n_o, ddr3_we_n_o};
  endfunction

  task automatic do_config(input logic [31:0] word, input logic [3:0] sel, input logic [2:0] lat);
    int n;
    cfg_data_i = word;
    cfg_req_i  = 1'b1;
    n = 0;
    while (cfg_ack_o !== 1'b1 && n < 16)
    begin
      tick();
      n++;
    end
    if (cfg_ack_o !== 1'b1)
    begin
      $display("Timed out at %0t waiting for cfg_ack_o to rise", $time);
      tmo_cnt++;
    end
    else
    begin
      check_val(64'(n), 64'd1, "cycles from cfg_req_i to cfg_ack_o");
    end
    cfg_req_i = 1'b0;
    n = 0;
    while (cfg_ack_o !== 1'b0 && n < 16)
    begin
      tick();
      n++;
    end
    if (cfg_ack_o !== 1'b0)
    begin
      $display("Timed out at %0t waiting for cfg_ack_o to fall", $time);
      tmo_cnt++;
    end
    else
    begin
      check_val(64'(n), 64'd1, "cycles from cfg_req_i low to cfg_ack_o low");
    end
    cur_sel = sel;
    cur_lat = lat;
  endtask

  task automatic run_cmd(input logic [31:0] addr, input logic [31:0] bank, input logic [31:0] ctl);
    dfi_address_i = addr[13:0];
    dfi_bank_i    = bank[2:0];
    {dfi_cas_n_i, dfi_cke_i, dfi_cs_n_i, dfi_odt_i, dfi_ras_n_i, dfi_reset_n_i,
     dfi_we_n_i} = ctl[6:0];
    // Pins keep the previous command until the next rising edge
    #1;
    check_val(64'(cmd_pins()), 64'(last_cmd), "command pins before the clock edge");
    tick();
    last_cmd = {addr[13:0], bank[2:0], ctl[6:0]};
    check_val(64'(cmd_pins()), 64'(last_cmd), "command pins");
  endtask

  task automatic run_write(input logic [3:0] mask, input logic [31:0] pattern,
                           input logic [31:0] cycles);
    logic [31:0] data;
    logic [3:0]  m;
    logic [2:0]  en_hist;
    int          i;
    en_hist = 3'b000;
    for (i = 0; i < cycles + 3; i++)
    begin
      data = $random(seed);
      m    = mask ^ i[3:0];
      dfi_wrdata_i      = data;
      dfi_wrdata_mask_i = m;
      dfi_wrdata_en_i   = (i < cycles) ? pattern[i] : 1'b0;
      en_hist = {en_hist[1:0], dfi_wrdata_en_i};
      #1;
      check_val(64'(ddr3_wrdata_o), 64'(last_data), "ddr3_wrdata_o before the clock edge");
      check_val(64'(ddr3_wrmask_o), 64'(last_mask), "ddr3_wrmask_o before the clock edge");
      tick();
      check_val(64'(ddr3_wrdata_o), 64'(data), "ddr3_wrdata_o");
      check_val(64'(ddr3_wrmask_o), 64'(m), "ddr3_wrmask_o");
      check_val(64'(dq_oe_o), 64'(en_hist[2]), "dq_oe_o");
      last_data = data;
      last_mask = m;
    end
  endtask

  task automatic run_read(input logic [31:0] pattern, input logic [31:0] cycles);
    logic [63:0] beats;
    logic [31:0] exp_word;
    logic [31:0] prev_word;
    logic [15:0] en_hist;
    int          lo_k;
    int          hi_k;
    int          i;
    en_hist = '0;
    // Low half is beat sel mod 4, high half is beat (sel div 4 + 1) mod 4
    lo_k = int'(cur_sel) % 4;
    hi_k = (int'(cur_sel) / 4 + 1) % 4;
    for (i = 0; i < cycles + 8; i++)
    begin
      beats = {$random(seed), $random(seed)};
      rd_beats_i      = beats;
      dfi_rddata_en_i = (i < cycles) ? pattern[i] : 1'b0;
      en_hist   = {en_hist[14:0], dfi_rddata_en_i};
      exp_word  = {beats[hi_k*16 +: 16], beats[lo_k*16 +: 16]};
      prev_word = {last_beats[hi_k*16 +: 16], last_beats[lo_k*16 +: 16]};
      #1;
      check_val(64'(dfi_rddata_o), 64'(prev_word), "dfi_rddata_o before the clock edge");
      tick();
      check_val(64'(dfi_rddata_o), 64'(exp_word), "dfi_rddata_o");
      check_val(64'(dfi_rddata_valid_o), 64'(en_hist[cur_lat]), "dfi_rddata_valid_o");
      last_beats = beats;
    end
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial
  begin
    seed    = 88435;
    err_cnt = 0;
    tmo_cnt = 0;
    clk_i   = 1'b0;
    rst_i   = 1'b1;
    cfg_req_i  = 1'b0;
    cfg_data_i = '0;
    dfi_address_i = '0;
    dfi_bank_i    = '0;
    {dfi_cas_n_i, dfi_cke_i, dfi_cs_n_i, dfi_odt_i, dfi_ras_n_i, dfi_reset_n_i,
     dfi_we_n_i} = 7'd0;
    dfi_wrdata_i      = '0;
    dfi_wrdata_mask_i = '0;
    dfi_wrdata_en_i   = 1'b0;
    rd_beats_i        = '0;
    dfi_rddata_en_i   = 1'b0;
    cur_sel = 4'd15;
    cur_lat = 3'd4;
    last_cmd   = '0;
    last_data  = '0;
    last_mask  = '0;
    last_beats = '0;
    repeat (4) @(negedge clk_i);
    check_val(64'({cfg_ack_o, dq_oe_o, dfi_rddata_valid_o}), 64'd0, "flags after reset");
    check_val(64'(cmd_pins()), 64'd0, "command pins after reset");
    rst_i = 1'b0;

    fd = $fopen("ddr3_phy_vectors.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open ddr3_phy_vectors.txt");
      err_cnt++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        tok  = '0;
        code = $fscanf(fd, "%s", tok);
        if (code != 1)
          break;
        if (tok == {56'd0, "#"})
        begin
          code = $fgets(line, fd);
        end
        else
        begin
          code = $fscanf(fd, "%h %h %h", f1, f2, f3);
          if (code != 3)
          begin
            $display("Vector file has a record with missing fields");
            err_cnt++;
            break;
          end
          case (tok)
            {40'd0, "cfg"}: do_config(f1, f2[3:0], f3[2:0]);
            {40'd0, "cmd"}: run_cmd(f1, f2, f3);
            {48'd0, "wr"}:  run_write(f1[3:0], f2, f3);
            {48'd0, "rd"}:  run_read(f1, f2);
            default:
            begin
              $display("Vector file has an unknown record type");
              err_cnt++;
            end
          endcase
        end
      end
      $fclose(fd);
    end

    $display("Errors: %0d check failures, %0d timeouts, %0d assertion failures",
             err_cnt, tmo_cnt, dut_i.u_checker.fail_cnt);
    if (err_cnt == 0 && tmo_cnt == 0 && dut_i.u_checker.fail_cnt == 0)
    begin
      $display("test passed");
    end
    else
    begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== ddr3_phy_checker.sv ====
`timescale 1ns/10ps

module ddr3_phy_checker
(
  input logic clk_i,
  input logic rst_i,
  input logic cfg_req_i,
  input logic cfg_ack_i,
  input logic wr_en_i,
  input logic dq_oe_i,
  input logic ras_n_dfi_i,
  input logic ras_n_pin_i
);

  // Failed assertions so far
  int fail_cnt = 0;

  // Acknowledge only ever answers a pending request
  ack_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(cfg_ack_i) |-> $past(cfg_req_i))
  else
  begin
    fail_cnt++;
    $error("cfg_ack_o rose without cfg_req_i");
  end

  // Three-stage enable pipeline
  oe_follows_en: assert property (@(posedge clk_i) disable iff (rst_i)
    !$past(rst_i, 3) |-> (dq_oe_i == $past(wr_en_i, 3)))
  else
  begin
    fail_cnt++;
    $error("dq_oe_o does not match the write enable from three cycles back");
  end

  // One register between DFI and the pin
  ras_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
    !$past(rst_i) |-> (ras_n_pin_i == $past(ras_n_dfi_i)))
  else
  begin
    fail_cnt++;
    $error("ddr3_ras_n_o does not match dfi_ras_n_i from one cycle back");
  end

endmodule

bind ddr3_dfi_phy_core ddr3_phy_checker u_checker
(
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .cfg_req_i   (cfg_req_i),
  .cfg_ack_i   (cfg_ack_o),
  .wr_en_i     (dfi_wrdata_en_i),
  .dq_oe_i     (dq_oe_o),
  .ras_n_dfi_i (dfi_ras_n_i),
  .ras_n_pin_i (ddr3_ras_n_o)
);

// ==== ddr3_dfi_phy_core.sv ====
`timescale 1ns/10ps

module ddr3_dfi_phy_core
(
  input  logic                                               clk_i,
  input  logic                                               rst_i,

  // Configuration handshake
  input  logic                                               cfg_req_i,
  input  logic [ddr3_phy_pkg::CFG_W-1:0]                     cfg_data_i,
  output logic                                               cfg_ack_o,

  // DFI command
  input  logic [ddr3_phy_pkg::ADDR_W-1:0]                    dfi_address_i,
  input  logic [ddr3_phy_pkg::BANK_W-1:0]                    dfi_bank_i,
  input  logic                                               dfi_cas_n_i,
  input  logic                                               dfi_cke_i,
  input  logic                                               dfi_cs_n_i,
  input  logic                                               dfi_odt_i,
  input  logic                                               dfi_ras_n_i,
  input  logic                                               dfi_reset_n_i,
  input  logic                                               dfi_we_n_i,

  // DFI write
  input  logic [ddr3_phy_pkg::DFI_DATA_W-1:0]                dfi_wrdata_i,
  input  logic [ddr3_phy_pkg::DFI_MASK_W-1:0]                dfi_wrdata_mask_i,
  input  logic                                               dfi_wrdata_en_i,

  // DFI read
  input  logic [ddr3_phy_pkg::BEATS*ddr3_phy_pkg::DQ_W-1:0]  rd_beats_i,
  input  logic                                               dfi_rddata_en_i,
  output logic [ddr3_phy_pkg::DFI_DATA_W-1:0]                dfi_rddata_o,
  output logic                                               dfi_rddata_valid_o,

  // DDR3 side
  output logic [ddr3_phy_pkg::ADDR_W-1:0]                    ddr3_addr_o,
  output logic [ddr3_phy_pkg::BANK_W-1:0]                    ddr3_ba_o,
  output logic                                               ddr3_cas_n_o,
  output logic                                               ddr3_cke_o,
  output logic                                               ddr3_cs_n_o,
  output logic                                               ddr3_odt_o,
  output logic                                               ddr3_ras_n_o,
  output logic                                               ddr3_reset_n_o,
  output logic                                               ddr3_we_n_o,
  output logic [ddr3_phy_pkg::DFI_DATA_W-1:0]                ddr3_wrdata_o,
  output logic [ddr3_phy_pkg::DFI_MASK_W-1:0]                ddr3_wrmask_o,
  output logic                                               dq_oe_o
);

  logic [ddr3_phy_pkg::RDSEL_W-1:0]  rd_sel;
  logic [ddr3_phy_pkg::RDLAT_W-1:0]  rd_lat;

  ddr3_phy_cfg u_cfg
  (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .cfg_req_i  (cfg_req_i),
    .cfg_data_i (cfg_data_i),
    .cfg_ack_o  (cfg_ack_o),
    .rd_sel_o   (rd_sel),
    .rd_lat_o   (rd_lat)
  );

  ddr3_phy_cmd u_cmd
  (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .dfi_address_i  (dfi_address_i),
    .dfi_bank_i     (dfi_bank_i),
    .dfi_cas_n_i    (dfi_cas_n_i),
    .dfi_cke_i      (dfi_cke_i),
    .dfi_cs_n_i     (dfi_cs_n_i),
    .dfi_odt_i      (dfi_odt_i),
    .dfi_ras_n_i    (dfi_ras_n_i),
    .dfi_reset_n_i  (dfi_reset_n_i),
    .dfi_we_n_i     (dfi_we_n_i),
    .ddr3_addr_o    (ddr3_addr_o),
    .ddr3_ba_o      (ddr3_ba_o),
    .ddr3_cas_n_o   (ddr3_cas_n_o),
    .ddr3_cke_o     (ddr3_cke_o),
    .ddr3_cs_n_o    (ddr3_cs_n_o),
    .ddr3_odt_o     (ddr3_odt_o),
    .ddr3_ras_n_o   (ddr3_ras_n_o),
    .ddr3_reset_n_o (ddr3_reset_n_o),
    .ddr3_we_n_o    (ddr3_we_n_o)
  );

  ddr3_phy_wr u_wr
  (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .dfi_wrdata_i      (dfi_wrdata_i),
    .dfi_wrdata_mask_i (dfi_wrdata_mask_i),
    .dfi_wrdata_en_i   (dfi_wrdata_en_i),
    .ddr3_wrdata_o     (ddr3_wrdata_o),
    .ddr3_wrmask_o     (ddr3_wrmask_o),
    .dq_oe_o           (dq_oe_o)
  );

  ddr3_phy_rd u_rd
  (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .rd_beats_i         (rd_beats_i),
    .rd_sel_i           (rd_sel),
    .rd_lat_i           (rd_lat),
    .dfi_rddata_en_i    (dfi_rddata_en_i),
    .dfi_rddata_o       (dfi_rddata_o),
    .dfi_rddata_valid_o (dfi_rddata_valid_o)
  );

endmodule

// ==== ddr3_phy_rd.sv ====
`timescale 1ns/10ps

module ddr3_phy_rd
(
  input  logic                                                  clk_i,
  input  logic                                                  rst_i,
  input  logic [ddr3_phy_pkg::BEATS*ddr3_phy_pkg::DQ_W-1:0]     rd_beats_i,
  input  logic [ddr3_phy_pkg::RDSEL_W-1:0]                      rd_sel_i,
  input  logic [ddr3_phy_pkg::RDLAT_W-1:0]                      rd_lat_i,
  input  logic                                                  dfi_rddata_en_i,
  output logic [ddr3_phy_pkg::DFI_DATA_W-1:0]                   dfi_rddata_o,
  output logic                                                  dfi_rddata_valid_o
);

  logic [1:0]                             lo_idx;
  logic [1:0]                             hi_idx;
  logic [ddr3_phy_pkg::DQ_W-1:0]          lo_beat;
  logic [ddr3_phy_pkg::DQ_W-1:0]          hi_beat;
  logic [ddr3_phy_pkg::DFI_DATA_W-1:0]    rddata_q;
  logic [ddr3_phy_pkg::RD_SHIFT_W-1:0]    rd_en_q;
  logic [ddr3_phy_pkg::RD_SHIFT_W-1:0]    rd_en_d;

  // --------------------------------------------------------------------------
  // Beat selection
  // --------------------------------------------------------------------------
  // rd_sel[1:0] picks the low beat; rd_sel[3:2] plus one (wrapping)
  // picks the high beat
  assign lo_idx = rd_sel_i[1:0];
  assign hi_idx = rd_sel_i[3:2] + 2'd1;

  assign lo_beat = rd_beats_i[lo_idx*ddr3_phy_pkg::DQ_W +: ddr3_phy_pkg::DQ_W];
  assign hi_beat = rd_beats_i[hi_idx*ddr3_phy_pkg::DQ_W +: ddr3_phy_pkg::DQ_W];

  always_ff @(posedge clk_i)
  begin
    rddata_q <= {hi_beat, lo_beat};
  end

  assign dfi_rddata_o = rddata_q;

  // --------------------------------------------------------------------------
  // Read valid
  // --------------------------------------------------------------------------
  // Enable enters at slot rd_lat and walks down to slot 0.
  // Each slot holds one read, so back-to-back enables stay separate
  always_comb
  begin
    rd_en_d           = {1'b0, rd_en_q[ddr3_phy_pkg::RD_SHIFT_W-1:1]};
    rd_en_d[rd_lat_i] = dfi_rddata_en_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      rd_en_q <= '0;
    end
    else
    begin
      rd_en_q <= rd_en_d;
    end
  end

  assign dfi_rddata_valid_o = rd_en_q[0];

endmodule

// ==== ddr3_phy_wr.sv ====
`timescale 1ns/10ps

module ddr3_phy_wr
(
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic [ddr3_phy_pkg::DFI_DATA_W-1:0]  dfi_wrdata_i,
  input  logic [ddr3_phy_pkg::DFI_MASK_W-1:0]  dfi_wrdata_mask_i,
  input  logic                                 dfi_wrdata_en_i,
  output logic [ddr3_phy_pkg::DFI_DATA_W-1:0]  ddr3_wrdata_o,
  output logic [ddr3_phy_pkg::DFI_MASK_W-1:0]  ddr3_wrmask_o,
  output logic                                 dq_oe_o
);

  logic [ddr3_phy_pkg::DFI_DATA_W-1:0]  wrdata_q;
  logic [ddr3_phy_pkg::DFI_MASK_W-1:0]  wrmask_q;
  logic [2:0]                           wr_en_q;

  // --------------------------------------------------------------------------
  // Write data and mask
  // --------------------------------------------------------------------------
  // Staged one cycle ahead of the serializers
  always_ff @(posedge clk_i)
  begin
    wrdata_q <= dfi_wrdata_i;
    wrmask_q <= dfi_wrdata_mask_i;
  end

  assign ddr3_wrdata_o = wrdata_q;
  assign ddr3_wrmask_o = wrmask_q;

  // --------------------------------------------------------------------------
  // Output enable
  // --------------------------------------------------------------------------
  // Three stages line the DQ/DQS enable up with the serialized data.
  // Active high, so the bus is released after reset
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      wr_en_q <= 3'b000;
    end
    else
    begin
      wr_en_q <= {wr_en_q[1:0], dfi_wrdata_en_i};
    end
  end

  assign dq_oe_o = wr_en_q[2];

endmodule

// ==== ddr3_phy_cmd.sv ====
`timescale 1ns/10ps

module ddr3_phy_cmd
(
  input  logic                             clk_i,
  input  logic                             rst_i,
  input  logic [ddr3_phy_pkg::ADDR_W-1:0]  dfi_address_i,
  input  logic [ddr3_phy_pkg::BANK_W-1:0]  dfi_bank_i,
  input  logic                             dfi_cas_n_i,
  input  logic                             dfi_cke_i,
  input  logic                             dfi_cs_n_i,
  input  logic                             dfi_odt_i,
  input  logic                             dfi_ras_n_i,
  input  logic                             dfi_reset_n_i,
  input  logic                             dfi_we_n_i,
  output logic [ddr3_phy_pkg::ADDR_W-1:0]  ddr3_addr_o,
  output logic [ddr3_phy_pkg::BANK_W-1:0]  ddr3_ba_o,
  output logic                             ddr3_cas_n_o,
  output logic                             ddr3_cke_o,
  output logic                             ddr3_cs_n_o,
  output logic                             ddr3_odt_o,
  output logic                             ddr3_ras_n_o,
  output logic                             ddr3_reset_n_o,
  output logic                             ddr3_we_n_o
);

  // --------------------------------------------------------------------------
  // Command register
  // --------------------------------------------------------------------------
  // All pins launch from the same edge, so the command arrives aligned.
  // Zero after reset keeps reset_n low and the DRAM held in reset
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      ddr3_addr_o    <= '0;
      ddr3_ba_o      <= '0;
      ddr3_cas_n_o   <= 1'b0;
      ddr3_cke_o     <= 1'b0;
      ddr3_cs_n_o    <= 1'b0;
      ddr3_odt_o     <= 1'b0;
      ddr3_ras_n_o   <= 1'b0;
      ddr3_reset_n_o <= 1'b0;
      ddr3_we_n_o    <= 1'b0;
    end
    else
    begin
      ddr3_addr_o    <= dfi_address_i;
      ddr3_ba_o      <= dfi_bank_i;
      ddr3_cas_n_o   <= dfi_cas_n_i;
      ddr3_cke_o     <= dfi_cke_i;
      ddr3_cs_n_o    <= dfi_cs_n_i;
      ddr3_odt_o     <= dfi_odt_i;
      ddr3_ras_n_o   <= dfi_ras_n_i;
      ddr3_reset_n_o <= dfi_reset_n_i;
      ddr3_we_n_o    <= dfi_we_n_i;
    end
  end

endmodule

// ==== ddr3_phy_cfg.sv ====
`timescale 1ns/10ps

module ddr3_phy_cfg
(
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              cfg_req_i,
  input  logic [ddr3_phy_pkg::CFG_W-1:0]    cfg_data_i,
  output logic                              cfg_ack_o,
  output logic [ddr3_phy_pkg::RDSEL_W-1:0]  rd_sel_o,
  output logic [ddr3_phy_pkg::RDLAT_W-1:0]  rd_lat_o
);

  ddr3_phy_pkg::cfg_state_t              state_q;
  logic [ddr3_phy_pkg::RDSEL_W-1:0]      rd_sel_q;
  logic [ddr3_phy_pkg::RDLAT_W-1:0]      rd_lat_q;

  // --------------------------------------------------------------------------
  // Four-phase handshake
  // --------------------------------------------------------------------------
  // Fields are captured once, on the edge that leaves CFG_IDLE
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_q  <= ddr3_phy_pkg::CFG_IDLE;
      rd_sel_q <= ddr3_phy_pkg::RDSEL_RESET;
      rd_lat_q <= ddr3_phy_pkg::RDLAT_RESET;
    end
    else
    begin
      case (state_q)
        ddr3_phy_pkg::CFG_IDLE:
        begin
          if (cfg_req_i)
          begin
            rd_sel_q <= cfg_data_i[ddr3_phy_pkg::CFG_RDSEL_LSB +: ddr3_phy_pkg::RDSEL_W];
            rd_lat_q <= cfg_data_i[ddr3_phy_pkg::CFG_RDLAT_LSB +: ddr3_phy_pkg::RDLAT_W];
            state_q  <= ddr3_phy_pkg::CFG_ACK;
          end
        end
        ddr3_phy_pkg::CFG_ACK:
        begin
          // Hold ack until the requester drops req
          if (!cfg_req_i)
          begin
            state_q <= ddr3_phy_pkg::CFG_IDLE;
          end
        end
        default:
        begin
          state_q <= ddr3_phy_pkg::CFG_IDLE;
        end
      endcase
    end
  end

  assign cfg_ack_o = (state_q == ddr3_phy_pkg::CFG_ACK);
  assign rd_sel_o  = rd_sel_q;
  assign rd_lat_o  = rd_lat_q;

endmodule

// ==== ddr3_phy_pkg.sv ====
package ddr3_phy_pkg;

  // --------------------------------------------------------------------------
  // Data path widths
  // --------------------------------------------------------------------------
  // One beat on the 16-bit memory bus
  localparam int DQ_W = 16;

  // Beats captured per controller clock (4:1 deserialization)
  localparam int BEATS = 4;

  // DFI side carries two beats per controller clock
  localparam int DFI_DATA_W = 32;
  localparam int DFI_MASK_W = 4;

  // --------------------------------------------------------------------------
  // Command path widths
  // --------------------------------------------------------------------------
  localparam int ADDR_W = 14;
  localparam int BANK_W = 3;

  // --------------------------------------------------------------------------
  // Configuration word layout
  // --------------------------------------------------------------------------
  localparam int CFG_W   = 32;
  localparam int RDSEL_W = 4;
  localparam int RDLAT_W = 3;

  // Field positions
  localparam int CFG_RDSEL_LSB = 0;
  localparam int CFG_RDLAT_LSB = 8;

  // Values after reset
  localparam logic [RDSEL_W-1:0] RDSEL_RESET = 4'd15;
  localparam logic [RDLAT_W-1:0] RDLAT_RESET = 3'd4;

  // Read-valid shifter length, covers every rd_lat value
  localparam int RD_SHIFT_W = 8;

  // Configuration handshake FSM
  typedef enum logic [0:0] {
    CFG_IDLE = 1'b0,
    CFG_ACK  = 1'b1
  } cfg_state_t;

endpackage
